// File: hw/aria_params.svh
`ifndef ARIA_PARAMS_SVH
`define ARIA_PARAMS_SVH

// Datapath and storage sizes
`define ARIA_DATA_WIDTH 16
`define ARIA_REG_COUNT  16
`define ARIA_IMEM_DEPTH 256
`define ARIA_DMEM_DEPTH 256

// Instruction fields
`define ARIA_OP_MSB  15
`define ARIA_OP_LSB  12
`define ARIA_RD_MSB  11
`define ARIA_RD_LSB  8
`define ARIA_RA_MSB  7
`define ARIA_RA_LSB  4
`define ARIA_RB_MSB  3
`define ARIA_RB_LSB  0
`define ARIA_IMM_MSB 7
`define ARIA_IMM_LSB 0

`endif

// File: hw/aria_pkg.sv
`default_nettype none

package aria_pkg;

`include "aria_params.svh"

    typedef logic [`ARIA_DATA_WIDTH-1:0] word_t;
    typedef logic [`ARIA_DATA_WIDTH-1:0] instr_t;
    typedef logic [$clog2(`ARIA_IMEM_DEPTH)-1:0] addr_t;
    typedef logic [$clog2(`ARIA_REG_COUNT)-1:0] reg_idx_t;
    typedef logic [3:0] flags_t;              // N Z C V

    localparam int FLAG_N = 3;
    localparam int FLAG_Z = 2;
    localparam int FLAG_C = 1;
    localparam int FLAG_V = 0;

    // Write-back source select
    localparam logic [1:0] WB_ALU = 2'd0;
    localparam logic [1:0] WB_MEM = 2'd1;
    localparam logic [1:0] WB_IMM = 2'd2;
    localparam logic [1:0] WB_SW  = 2'd3;

    typedef enum logic [3:0] {
        ADD  = 4'd0,  SUB  = 4'd1,  AND  = 4'd2,  ORR  = 4'd3,
        EOR  = 4'd4,  LSL  = 4'd5,  LSR  = 4'd6,  ASR  = 4'd7,
        MOVI = 4'd8,  ADDI = 4'd9,  LDR  = 4'd10, STR  = 4'd11,
        IN   = 4'd12, OUT  = 4'd13, BCC  = 4'd14, HLT  = 4'd15
    } opcode_t;

    typedef enum logic [3:0] {
        AL = 4'd0, EQ = 4'd1, NE = 4'd2, MI = 4'd3, CS = 4'd4
    } cond_t;

    typedef enum logic [2:0] {
        IDLE, FETCH, DECODE, EXECUTE, WRITEBACK, HALTED
    } state_t;

endpackage

`default_nettype wire

// File: hw/aria_control.sv
`timescale 1ns/1ps
`default_nettype none

`include "aria_params.svh"

module aria_control (
    input  logic               clock,
    input  logic               rst_n,
    input  aria_pkg::instr_t   instr,
    input  aria_pkg::flags_t   flags,
    output aria_pkg::reg_idx_t rd_idx,
    output aria_pkg::reg_idx_t ra_idx,
    output aria_pkg::reg_idx_t rb_idx,
    output aria_pkg::word_t    imm,
    output logic               reg_we,
    output logic [1:0]         wb_sel,
    output logic               b_sel_imm,
    output aria_pkg::opcode_t  alu_op,
    output logic               upd_nz,
    output logic               upd_cv,
    output logic               dmem_we,
    output logic               out_we,
    output logic               imem_en,
    output logic               pc_step,
    output logic               pc_load,
    output logic               halted
);
    import aria_pkg::*;

    state_t  state;
    state_t  state_nxt;
    instr_t  ir;
    opcode_t op;
    cond_t   cond;
    logic [7:0] imm8;
    logic    in_wb;
    logic    take_branch;

    // ####################################################################
    // Sequencer
    // ####################################################################

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state <= IDLE;
            ir    <= '0;
        end else begin
            state <= state_nxt;
            if (state == DECODE) begin
                ir <= instr;                          // Fetched word is valid here
            end
        end
    end

    always_comb begin
        case (state)
            IDLE:      state_nxt = FETCH;
            FETCH:     state_nxt = DECODE;
            DECODE:    state_nxt = EXECUTE;
            EXECUTE:   state_nxt = WRITEBACK;
            WRITEBACK: state_nxt = (op == HLT) ? HALTED : FETCH;
            HALTED:    state_nxt = HALTED;              // Left only by reset
            default:   state_nxt = IDLE;
        endcase
    end

    // ####################################################################
    // Decode
    // ####################################################################

    assign op    = opcode_t'(ir[`ARIA_OP_MSB:`ARIA_OP_LSB]);
    assign cond  = cond_t'(ir[`ARIA_RD_MSB:`ARIA_RD_LSB]);
    assign imm8  = ir[`ARIA_IMM_MSB:`ARIA_IMM_LSB];
    assign in_wb = (state == WRITEBACK);

    assign rd_idx = ir[`ARIA_RD_MSB:`ARIA_RD_LSB];
    assign ra_idx = (op == ADDI) ? ir[`ARIA_RD_MSB:`ARIA_RD_LSB]   // ADDI reads rd
                                 : ir[`ARIA_RA_MSB:`ARIA_RA_LSB];
    assign rb_idx = ir[`ARIA_RB_MSB:`ARIA_RB_LSB];

    assign imm = (op == MOVI) ? {{(`ARIA_DATA_WIDTH-8){1'b0}}, imm8}
                              : {{(`ARIA_DATA_WIDTH-8){imm8[7]}}, imm8};

    assign alu_op    = op;
    assign b_sel_imm = (op == MOVI) || (op == ADDI);

    always_comb begin
        case (op)
            MOVI:    wb_sel = WB_IMM;
            LDR:     wb_sel = WB_MEM;
            IN:      wb_sel = WB_SW;
            default: wb_sel = WB_ALU;
        endcase
    end

    always_comb begin
        case (cond)
            AL:      take_branch = 1'b1;
            EQ:      take_branch = flags[FLAG_Z];
            NE:      take_branch = !flags[FLAG_Z];
            MI:      take_branch = flags[FLAG_N];
            CS:      take_branch = flags[FLAG_C];
            default: take_branch = 1'b0;           // Unassigned codes never branch
        endcase
    end

    assign imem_en = (state == FETCH);
    assign dmem_we = (state == EXECUTE) && (op == STR);
    assign reg_we  = in_wb && (op inside {ADD, SUB, AND, ORR, EOR, LSL, LSR, ASR,
                                          MOVI, ADDI, LDR, IN});
    assign upd_nz  = in_wb && (op inside {ADD, SUB, AND, ORR, EOR, LSL, LSR, ASR, ADDI});
    assign upd_cv  = in_wb && (op inside {ADD, SUB, ADDI, LSL, LSR, ASR});
    assign out_we  = in_wb && (op == OUT);
    assign pc_load = in_wb && (op == BCC) && take_branch;
    assign pc_step = in_wb && (op != HLT) && !pc_load;
    assign halted  = (state == HALTED);

endmodule

`default_nettype wire

// File: hw/aria_pc.sv
`timescale 1ns/1ps
`default_nettype none

module aria_pc (
    input  logic            clock,
    input  logic            rst_n,
    input  logic            pc_step,
    input  logic            pc_load,
    input  aria_pkg::word_t offset,
    output aria_pkg::addr_t pc
);
    import aria_pkg::*;

    addr_t pc_inc;
    addr_t branch_target;

    assign pc_inc        = pc + addr_t'(1);
    assign branch_target = pc_inc + offset[$bits(addr_t)-1:0];   // Wraps within memory

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (pc_load) begin
            pc <= branch_target;
        end else if (pc_step) begin
            pc <= pc_inc;
        end
    end

endmodule

`default_nettype wire

// File: hw/aria_regbank.sv
`timescale 1ns/1ps
`default_nettype none

`include "aria_params.svh"

module aria_regbank (
    input  logic               clock,
    input  logic               rst_n,
    input  aria_pkg::reg_idx_t ra_idx,
    input  aria_pkg::reg_idx_t rb_idx,
    input  aria_pkg::reg_idx_t rd_idx,
    input  logic               we,
    input  aria_pkg::word_t    wdata,
    output aria_pkg::word_t    a_bus,
    output aria_pkg::word_t    b_bus,
    output aria_pkg::word_t    d_bus
);
    import aria_pkg::*;

    word_t regs [`ARIA_REG_COUNT];

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < `ARIA_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[rd_idx] <= wdata;
        end
    end

    // Combinational read ports
    assign a_bus = regs[ra_idx];
    assign b_bus = regs[rb_idx];
    assign d_bus = regs[rd_idx];                          // Store data

endmodule

`default_nettype wire

// File: hw/aria_shifter.sv
`timescale 1ns/1ps
`default_nettype none

`include "aria_params.svh"

module aria_shifter (
    input  aria_pkg::word_t   a_bus,
    input  aria_pkg::word_t   b_bus,
    input  aria_pkg::word_t   imm,
    input  logic              b_sel_imm,
    input  aria_pkg::opcode_t alu_op,
    input  logic              c_in,
    output aria_pkg::word_t   b_out,
    output aria_pkg::word_t   shift_result,
    output logic              shift_carry
);
    import aria_pkg::*;

    localparam int W  = `ARIA_DATA_WIDTH;
    localparam int AW = $clog2(W);

    logic [AW-1:0]  amt;
    logic [W:0]     lsl_ext;
    logic [W:0]     lsr_ext;
    logic signed [W:0] asr_ext;

    assign b_out = b_sel_imm ? imm : b_bus;
    assign amt   = b_bus[AW-1:0];

    // One guard bit catches the last bit shifted out
    assign lsl_ext = {1'b0, a_bus} << amt;
    assign lsr_ext = {a_bus, 1'b0} >> amt;
    assign asr_ext = $signed({a_bus, 1'b0}) >>> amt;

    always_comb begin
        shift_result = a_bus;
        shift_carry  = c_in;
        case (alu_op)
            LSL: begin
                shift_result = lsl_ext[W-1:0];
                shift_carry  = lsl_ext[W];
            end
            LSR: begin
                shift_result = lsr_ext[W:1];
                shift_carry  = lsr_ext[0];
            end
            ASR: begin
                shift_result = asr_ext[W:1];
                shift_carry  = asr_ext[0];
            end
            default: ;
        endcase
        if (amt == '0) begin
            shift_carry = c_in;                           // Zero shift keeps C
        end
    end

endmodule

`default_nettype wire

// File: hw/aria_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "aria_params.svh"

module aria_alu (
    input  logic              clock,
    input  logic              rst_n,
    input  aria_pkg::word_t   a_bus,
    input  aria_pkg::word_t   b_out,
    input  aria_pkg::word_t   shift_result,
    input  logic              shift_carry,
    input  aria_pkg::opcode_t alu_op,
    input  logic              upd_nz,
    input  logic              upd_cv,
    output aria_pkg::word_t   result,
    output aria_pkg::flags_t  flags
);
    import aria_pkg::*;

    localparam int W   = `ARIA_DATA_WIDTH;
    localparam int MSB = W - 1;

    logic [W:0] add_ext;
    logic [W:0] sub_ext;
    logic       c_new;
    logic       v_new;

    assign add_ext = {1'b0, a_bus} + {1'b0, b_out};
    assign sub_ext = {1'b0, a_bus} + {1'b0, ~b_out} + 1'b1;   // Carry set means no borrow

    always_comb begin
        result = b_out;
        c_new  = flags[FLAG_C];
        v_new  = flags[FLAG_V];
        case (alu_op)
            ADD, ADDI: begin
                result = add_ext[MSB:0];
                c_new  = add_ext[W];
                v_new  = (a_bus[MSB] == b_out[MSB]) && (result[MSB] != a_bus[MSB]);
            end
            SUB: begin
                result = sub_ext[MSB:0];
                c_new  = sub_ext[W];
                v_new  = (a_bus[MSB] != b_out[MSB]) && (result[MSB] != a_bus[MSB]);
            end
            AND: result = a_bus & b_out;
            ORR: result = a_bus | b_out;
            EOR: result = a_bus ^ b_out;
            LSL, LSR, ASR: begin
                result = shift_result;
                c_new  = shift_carry;                     // V is kept
            end
            default: ;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            flags <= '0;
        end else begin
            if (upd_nz) begin
                flags[FLAG_N] <= result[MSB];
                flags[FLAG_Z] <= (result == '0);
            end
            if (upd_cv) begin
                flags[FLAG_C] <= c_new;
                flags[FLAG_V] <= v_new;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/aria_memory.sv
`timescale 1ns/1ps
`default_nettype none

`include "aria_params.svh"

module aria_memory (
    input  logic             clock,
    input  logic             prog_we,
    input  aria_pkg::addr_t  prog_addr,
    input  aria_pkg::instr_t prog_data,
    input  logic             imem_en,
    input  aria_pkg::addr_t  iaddr,
    input  aria_pkg::addr_t  daddr,
    input  logic             dmem_we,
    input  aria_pkg::word_t  wdata,
    output aria_pkg::instr_t instr,
    output aria_pkg::word_t  rdata
);
    import aria_pkg::*;

    instr_t imem [`ARIA_IMEM_DEPTH];
    word_t  dmem [`ARIA_DMEM_DEPTH];

    // ####################################################################
    // Instruction array
    // ####################################################################

    always_ff @(posedge clock) begin
        if (prog_we) begin
            imem[prog_addr] <= prog_data;                 // Program load
        end
        if (imem_en) begin
            instr <= imem[iaddr];                         // Held until next fetch
        end
    end

    // ####################################################################
    // Data array
    // ####################################################################

    always_ff @(posedge clock) begin
        if (dmem_we) begin
            dmem[daddr] <= wdata;
        end
        rdata <= dmem[daddr];
    end

endmodule

`default_nettype wire

// File: hw/aria_core.sv
`timescale 1ns/1ps
`default_nettype none

module aria_core (
    input  logic             clock,
    input  logic             rst_n,
    input  logic             prog_we,
    input  aria_pkg::addr_t  prog_addr,
    input  aria_pkg::instr_t prog_data,
    input  aria_pkg::word_t  sw,
    output aria_pkg::word_t  led,
    output logic             led_strobe,
    output aria_pkg::flags_t flags,
    output aria_pkg::addr_t  pc,
    output logic             halted
);
    import aria_pkg::*;

    instr_t   instr;
    reg_idx_t rd_idx;
    reg_idx_t ra_idx;
    reg_idx_t rb_idx;
    word_t    imm;
    logic     reg_we;
    logic [1:0] wb_sel;
    logic     b_sel_imm;
    opcode_t  alu_op;
    logic     upd_nz;
    logic     upd_cv;
    logic     dmem_we;
    logic     out_we;
    logic     imem_en;
    logic     pc_step;
    logic     pc_load;
    word_t    a_bus;
    word_t    b_bus;
    word_t    d_bus;
    word_t    b_out;
    word_t    shift_result;
    logic     shift_carry;
    word_t    result;
    word_t    rdata;
    word_t    wb_data;
    addr_t    daddr;

    assign daddr = a_bus[$bits(addr_t)-1:0];             // Low bits of ra address data

    aria_control control_i (
        .clock, .rst_n, .instr, .flags,
        .rd_idx, .ra_idx, .rb_idx, .imm,
        .reg_we, .wb_sel, .b_sel_imm, .alu_op,
        .upd_nz, .upd_cv, .dmem_we, .out_we,
        .imem_en, .pc_step, .pc_load, .halted
    );

    aria_pc pc_i (
        .clock, .rst_n, .pc_step, .pc_load,
        .offset (imm),
        .pc
    );

    aria_regbank regbank_i (
        .clock, .rst_n, .ra_idx, .rb_idx, .rd_idx,
        .we    (reg_we),
        .wdata (wb_data),
        .a_bus, .b_bus, .d_bus
    );

    aria_shifter shifter_i (
        .a_bus, .b_bus, .imm, .b_sel_imm, .alu_op,
        .c_in (flags[FLAG_C]),
        .b_out, .shift_result, .shift_carry
    );

    aria_alu alu_i (
        .clock, .rst_n, .a_bus, .b_out, .shift_result, .shift_carry,
        .alu_op, .upd_nz, .upd_cv, .result, .flags
    );

    aria_memory memory_i (
        .clock, .prog_we, .prog_addr, .prog_data, .imem_en,
        .iaddr (pc),
        .daddr, .dmem_we,
        .wdata (d_bus),
        .instr, .rdata
    );

    always_comb begin
        case (wb_sel)
            WB_MEM:  wb_data = rdata;
            WB_IMM:  wb_data = imm;
            WB_SW:   wb_data = sw;
            default: wb_data = result;
        endcase
    end

    // Strobe is high while led shows the new value
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            led        <= '0;
            led_strobe <= 1'b0;
        end else begin
            led_strobe <= out_we;
            if (out_we) begin
                led <= a_bus;
            end
        end
    end

endmodule

`default_nettype wire

// File: testbench/aria_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "aria_params.svh"

module aria_tb;
    import aria_pkg::*;

    logic     clock = 1'b0;
    logic     rst_n;
    logic     prog_we;
    addr_t    prog_addr;
    instr_t   prog_data;
    word_t    sw;
    word_t    led;
    logic     led_strobe;
    flags_t   flags;
    addr_t    pc;
    logic     halted;

    instr_t   prog [`ARIA_IMEM_DEPTH];
    int       prog_len;
    word_t    sw_value;
    word_t    exp_outs [$];
    flags_t   exp_flags;
    addr_t    exp_pc;
    string    test_name;
    logic     checking = 1'b0;
    logic     strobe_prev = 1'b0;
    int       out_idx;
    int       test_errors;
    int       pass_count = 0;
    int       fail_count = 0;
    int       cycle_count = 0;
    int       cycle_limit = 8;                          // Grows as each test is queued

    aria_core dut_i (
        .clock, .rst_n, .prog_we, .prog_addr, .prog_data, .sw,
        .led, .led_strobe, .flags, .pc, .halted
    );

    always #20 clock = ~clock;

    // ####################################################################
    // Program construction
    // ####################################################################

    function automatic instr_t enc_reg(input opcode_t op, input int rd, input int ra,
                                       input int rb);
        return {op, reg_idx_t'(rd), reg_idx_t'(ra), reg_idx_t'(rb)};
    endfunction

    function automatic instr_t enc_imm(input opcode_t op, input int rd, input int imm);
        logic [7:0] imm8;
        imm8 = imm[7:0];
        return {op, reg_idx_t'(rd), imm8};
    endfunction

    function automatic void emit(input instr_t ins);
        prog[prog_len] = ins;
        prog_len++;
    endfunction

    task automatic arith_program();
        prog_len = 0;
        emit(enc_imm(ADDI, 1, -1));                     // 0 - 1 gives 0xffff
        emit(enc_reg(OUT, 0, 1, 0));
        emit(enc_reg(ADD, 4, 1, 1));                    // Carry out
        emit(enc_reg(OUT, 0, 4, 0));
        emit(enc_imm(MOVI, 5, 1));
        emit(enc_imm(MOVI, 6, 15));
        emit(enc_reg(LSL, 7, 5, 6));
        emit(enc_reg(SUB, 8, 7, 5));                    // Signed overflow
        emit(enc_reg(OUT, 0, 8, 0));
        emit(enc_reg(ADD, 9, 8, 5));
        emit(enc_reg(OUT, 0, 9, 0));
        emit(enc_reg(SUB, 10, 5, 6));                   // Borrow
        emit(enc_reg(OUT, 0, 10, 0));
        emit(enc_reg(SUB, 11, 6, 6));                   // Zero
        emit(enc_reg(OUT, 0, 11, 0));
        emit(enc_reg(HLT, 0, 0, 0));
    endtask

    task automatic logic_shift_program();
        prog_len = 0;
        emit(enc_imm(MOVI, 7, 8'h81));
        emit(enc_imm(MOVI, 8, 1));
        emit(enc_imm(MOVI, 9, 15));
        emit(enc_reg(LSL, 12, 7, 9));
        emit(enc_reg(OUT, 0, 12, 0));
        emit(enc_reg(SUB, 3, 12, 8));                   // Sets V and C
        emit(enc_reg(OUT, 0, 3, 0));
        emit(enc_reg(ASR, 13, 12, 8));
        emit(enc_reg(OUT, 0, 13, 0));
        emit(enc_reg(ASR, 14, 12, 9));
        emit(enc_reg(OUT, 0, 14, 0));
        emit(enc_reg(LSR, 11, 7, 8));
        emit(enc_reg(OUT, 0, 11, 0));
        emit(enc_reg(LSL, 15, 7, 0));                   // Amount 0 keeps C
        emit(enc_reg(OUT, 0, 15, 0));
        emit(enc_imm(MOVI, 1, 8'hf0));
        emit(enc_imm(MOVI, 2, 8'h3c));
        emit(enc_reg(AND, 4, 1, 2));
        emit(enc_reg(OUT, 0, 4, 0));
        emit(enc_reg(ORR, 5, 1, 2));
        emit(enc_reg(OUT, 0, 5, 0));
        emit(enc_reg(EOR, 6, 1, 2));
        emit(enc_reg(OUT, 0, 6, 0));
        emit(enc_reg(HLT, 0, 0, 0));
    endtask

    task automatic load_store_program();
        prog_len = 0;
        emit(enc_imm(MOVI, 1, 8'h10));
        emit(enc_imm(MOVI, 2, 8'ha5));
        emit(enc_reg(STR, 2, 1, 0));
        emit(enc_imm(MOVI, 3, 8'hff));
        emit(enc_imm(ADDI, 2, 8'h11));
        emit(enc_reg(STR, 2, 3, 0));
        emit(enc_imm(MOVI, 4, 8'h12));
        emit(enc_imm(MOVI, 5, 8));
        emit(enc_reg(LSL, 4, 4, 5));
        emit(enc_imm(ADDI, 4, 8'h34));                  // Address 0x1234 lands on 0x34
        emit(enc_imm(ADDI, 2, -1));
        emit(enc_reg(STR, 2, 4, 0));
        emit(enc_imm(MOVI, 6, 8'h34));
        emit(enc_reg(LDR, 7, 6, 0));
        emit(enc_reg(OUT, 0, 7, 0));
        emit(enc_reg(LDR, 8, 1, 0));
        emit(enc_reg(OUT, 0, 8, 0));
        emit(enc_reg(LDR, 9, 3, 0));
        emit(enc_reg(OUT, 0, 9, 0));
        emit(enc_imm(MOVI, 12, 8'hff));
        emit(enc_reg(LSL, 12, 12, 5));
        emit(enc_imm(ADDI, 12, 8'h10));                 // 0xff10 aliases 0x10
        emit(enc_reg(LDR, 13, 12, 0));
        emit(enc_reg(OUT, 0, 13, 0));
        emit(enc_reg(HLT, 0, 0, 0));
    endtask

    task automatic io_program();
        prog_len = 0;
        emit(enc_reg(IN, 1, 0, 0));
        emit(enc_reg(OUT, 0, 1, 0));
        emit(enc_reg(IN, 2, 0, 0));
        emit(enc_reg(ADD, 3, 1, 2));
        emit(enc_reg(OUT, 0, 3, 0));
        emit(enc_reg(EOR, 4, 1, 2));
        emit(enc_reg(OUT, 0, 4, 0));
        emit(enc_reg(HLT, 0, 0, 0));
    endtask

    task automatic branch_program();
        prog_len = 0;
        emit(enc_imm(MOVI, 1, 5));
        emit(enc_reg(OUT, 0, 1, 0));                    // Loop top at 1
        emit(enc_imm(ADDI, 1, -1));
        emit(enc_imm(BCC, NE, -3));
        emit(enc_imm(BCC, EQ, 1));
        emit(enc_reg(OUT, 0, 1, 0));                    // Skipped
        emit(enc_imm(MOVI, 4, 1));
        emit(enc_imm(MOVI, 5, 15));
        emit(enc_reg(LSL, 6, 4, 5));
        emit(enc_imm(BCC, MI, 2));
        emit(enc_reg(OUT, 0, 4, 0));                    // Skipped
        emit(enc_reg(OUT, 0, 5, 0));                    // Skipped
        emit(enc_reg(OUT, 0, 6, 0));
        emit(enc_imm(BCC, EQ, 1));                      // Not taken
        emit(enc_reg(OUT, 0, 5, 0));
        emit(enc_reg(HLT, 0, 0, 0));
    endtask

    task automatic random_program();
        int         pick;
        logic [11:0] fields;
        opcode_t    op;
        prog_len = 0;
        for (int i = 0; i < 200; i++) begin
            pick = $urandom % 12;
            if (pick < 10) begin
                op = opcode_t'(pick);
            end else if (pick == 10) begin
                op = IN;
            end else begin
                op = OUT;
            end
            fields = $urandom;
            emit({op, fields});
        end
        emit(enc_reg(HLT, 0, 0, 0));
    endtask

    // ####################################################################
    // Reference model
    // ####################################################################

    function automatic void add_sub(input word_t a, input word_t b, input logic sub,
                                    output word_t res, output logic c, output logic v);
        int ua;
        int ub;
        int sa;
        int sb;
        int u;
        int s;
        ua = a;
        ub = b;
        sa = $signed(a);
        sb = $signed(b);
        if (sub) begin
            u = ua - ub;
            s = sa - sb;
            c = (ua >= ub);                             // No borrow
        end else begin
            u = ua + ub;
            s = sa + sb;
            c = (u > 65535);
        end
        res = u[15:0];
        v = (s > 32767) || (s < -32768);
    endfunction

    function automatic int run_model(input word_t sw_val);
        word_t   r [`ARIA_REG_COUNT];
        word_t   m [`ARIA_DMEM_DEPTH];
        instr_t  ins;
        opcode_t op;
        int      rd;
        int      ra;
        int      rb;
        word_t   a;
        word_t   b;
        word_t   res;
        logic    fn;
        logic    fz;
        logic    fc;
        logic    fv;
        logic    take;
        logic    done;
        int      pc_m;
        int      next_pc;
        int      count;
        exp_outs.delete();
        for (int i = 0; i < `ARIA_REG_COUNT; i++) begin
            r[i] = '0;
        end
        {fn, fz, fc, fv} = 4'b0000;
        pc_m = 0;
        count = 0;
        done = 1'b0;
        while (!done && count < 1000) begin
            ins = prog[pc_m];
            count++;
            op = opcode_t'(ins[15:12]);
            rd = ins[11:8];
            ra = ins[7:4];
            rb = ins[3:0];
            a = r[ra];
            b = r[rb];
            next_pc = (pc_m + 1) % 256;
            case (op)
                ADD, SUB, ADDI: begin
                    if (op == ADDI) begin
                        a = r[rd];
                        b = {{8{ins[7]}}, ins[7:0]};
                    end
                    add_sub(a, b, op == SUB, res, fc, fv);
                end
                AND: res = a & b;
                ORR: res = a | b;
                EOR: res = a ^ b;
                LSL, LSR, ASR: begin
                    res = a;
                    for (int k = 0; k < int'(b[3:0]); k++) begin
                        if (op == LSL) begin
                            fc = res[15];
                            res = res << 1;
                        end else begin
                            fc = res[0];
                            res = {(op == ASR) & res[15], res[15:1]};
                        end
                    end
                end
                MOVI: r[rd] = {8'h00, ins[7:0]};
                LDR:  r[rd] = m[r[ra][7:0]];
                STR:  m[r[ra][7:0]] = r[rd];
                IN:   r[rd] = sw_val;
                OUT:  exp_outs.push_back(a);
                BCC: begin
                    case (cond_t'(ins[11:8]))
                        AL:      take = 1'b1;
                        EQ:      take = fz;
                        NE:      take = !fz;
                        MI:      take = fn;
                        CS:      take = fc;
                        default: take = 1'b0;
                    endcase
                    if (take) begin
                        next_pc = (pc_m + 1 + int'(ins[7:0])) % 256;
                    end
                end
                default: begin
                    done = 1'b1;                        // HLT keeps pc
                    next_pc = pc_m;
                end
            endcase
            if (op inside {ADD, SUB, ADDI, AND, ORR, EOR, LSL, LSR, ASR}) begin
                r[rd] = res;
                fn = res[15];
                fz = (res == '0);
            end
            pc_m = next_pc;
        end
        exp_flags = {fn, fz, fc, fv};
        exp_pc = addr_t'(pc_m);
        return count;
    endfunction

    // ####################################################################
    // Checking and run control
    // ####################################################################

    always @(posedge clock) begin
        if (checking && led_strobe) begin
            assert (!strobe_prev) else begin
                $display("%s: led_strobe stayed high for more than one cycle", test_name);
                test_errors++;
            end
            assert (out_idx < exp_outs.size()) else begin
                $display("%s: led_strobe pulsed with no OUT left to expect", test_name);
                test_errors++;
            end
            if (out_idx < exp_outs.size()) begin
                assert (led === exp_outs[out_idx]) else begin
                    $display("error %s: led expected %h actual %h",
                             test_name, exp_outs[out_idx], led);
                    test_errors++;
                end
            end
            out_idx++;
        end
        strobe_prev = led_strobe;
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout after %0d cycles, the core did not halt in time", cycle_count);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    task automatic load_program();
        for (int i = 0; i < prog_len; i++) begin
            @(posedge clock);
            prog_we   <= 1'b1;
            prog_addr <= addr_t'(i);
            prog_data <= prog[i];
        end
        @(posedge clock);
        prog_we <= 1'b0;
        sw      <= sw_value;                            // Held for the whole run
    endtask

    task automatic run_test(input string name);
        int count;
        test_name = name;
        count = run_model(sw_value);
        cycle_limit += prog_len + 4 * count + 24;
        test_errors = 0;
        out_idx = 0;
        load_program();
        repeat (2) @(posedge clock);
        rst_n <= 1'b1;
        checking = 1'b1;
        while (halted !== 1'b1) begin
            @(posedge clock);
        end
        checking = 1'b0;
        assert (out_idx == exp_outs.size()) else begin
            $display("error %s: OUT count expected %0d actual %0d",
                     name, exp_outs.size(), out_idx);
            test_errors++;
        end
        assert (flags === exp_flags) else begin
            $display("error %s: flags expected %b actual %b", name, exp_flags, flags);
            test_errors++;
        end
        assert (pc === exp_pc) else begin
            $display("error %s: pc expected %0d actual %0d", name, exp_pc, pc);
            test_errors++;
        end
        rst_n <= 1'b0;
        if (test_errors == 0) begin
            $display("%s passed", name);
            pass_count++;
        end else begin
            $display("%s failed with %0d errors", name, test_errors);
            fail_count++;
        end
    endtask

    initial begin
        void'($urandom(32'h2fc));
        rst_n     = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        sw        = '0;
        sw_value  = '0;
        arith_program();
        run_test("arith_flags");
        logic_shift_program();
        run_test("logic_shift");
        load_store_program();
        run_test("load_store");
        sw_value = $urandom;
        io_program();
        run_test("io_port");
        branch_program();
        run_test("branching");
        sw_value = $urandom;
        random_program();
        run_test("random_program");
        $display("tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+hw
hw/aria_pkg.sv
hw/aria_control.sv
hw/aria_pc.sv
hw/aria_regbank.sv
hw/aria_shifter.sv
hw/aria_alu.sv
hw/aria_memory.sv
hw/aria_core.sv
testbench/aria_tb.sv

// File: Bender.yml
package:
  name: aria_core

sources:
  - include_dirs:
      - hw
    files:
      - hw/aria_pkg.sv
      - hw/aria_control.sv
      - hw/aria_pc.sv
      - hw/aria_regbank.sv
      - hw/aria_shifter.sv
      - hw/aria_alu.sv
      - hw/aria_memory.sv
      - hw/aria_core.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - testbench/aria_tb.sv
